// File: lsq.f
rtl/lsq_pkg.sv
rtl/store_queue.sv
rtl/load_queue.sv
rtl/mem_port_arbiter.sv
rtl/lsq_top.sv
tests/lsq_tb.sv

// File: Bender.yml
package:
  name: lsq

sources:
  - rtl/lsq_pkg.sv
  - rtl/store_queue.sv
  - rtl/load_queue.sv
  - rtl/mem_port_arbiter.sv
  - rtl/lsq_top.sv
  - target: test
    files:
      - tests/lsq_tb.sv

// File: tests/lsq_tb.sv
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

    localparam int N_OPS          = 200;
    localparam int SQ_DEPTH       = 8;             // DUT defaults
    localparam int LQ_DEPTH       = 8;
    localparam int TIMEOUT_CYCLES = N_OPS * 20;

    logic        clock, reset;
    logic        dispatch_valid_i, lsq_full_o;
    dispatch_t   dispatch_i;
    logic        store_data_valid_i;
    store_data_t store_data_i;
    logic        commit_valid_i;
    commit_t     commit_i;
    logic        wb_valid_o;
    load_wb_t    wb_load_o;
    wb_req_t     mem_req_o;
    wb_rsp_t     mem_rsp_i;

    integer seed;
    int     cycle_cnt;

    // Program and reference model
    logic  prog_is_store [N_OPS];
    addr_t prog_addr     [N_OPS];
    data_t prog_data     [N_OPS];
    data_t prog_exp      [N_OPS];        // Program-order value seen by a load
    bit    data_given [N_OPS], wb_seen [N_OPS], drained [N_OPS];
    int    rd_count   [N_OPS];           // Memory reads per load
    data_t slave_mem [16];
    data_t final_mem [16];

    int disp_ptr, data_ptr, data_wait, commit_ptr, wb_ptr, drain_ptr;
    int sq_cnt, lq_cnt, fwd_count;
    bit sq_full_seen, lq_full_seen;
    bit bus_active, drop_check, cap_we;
    int bus_wait;
    addr_t cap_adr;
    data_t cap_dat;

    lsq_top lsq_top_i (
        .clock, .reset, .dispatch_valid_i, .dispatch_i, .lsq_full_o,
        .store_data_valid_i, .store_data_i, .commit_valid_i, .commit_i,
        .wb_valid_o, .wb_load_o, .mem_req_o, .mem_rsp_i
    );

    always #50 clock = ~clock;

    // ==============================
    // Helpers and compare tasks
    // ==============================
    function automatic data_t init_word(int k);
        return 32'hc0de_0000 | data_t'(k << 2);          // Unique per address
    endfunction

    function automatic int next_store_index(int from);
        int j;
        j = from;
        while (j < N_OPS && !prog_is_store[j]) j++;
        return j;
    endfunction

    function automatic int next_load_index(int from);
        int j;
        j = from;
        while (j < N_OPS && prog_is_store[j]) j++;
        return j;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_rob(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_sel(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // ==============================
    // Program, reset and end of run
    // ==============================
    initial begin
        int word;
        seed = 32'ha7f3;
        clock = 1'b0;
        reset = 1'b0;
        dispatch_valid_i   = 1'b0;
        dispatch_i         = '0;
        store_data_valid_i = 1'b0;
        store_data_i       = '0;
        commit_valid_i     = 1'b0;
        commit_i           = '0;
        mem_rsp_i          = '0;
        for (int k = 0; k < 16; k++) begin
            slave_mem[k] = init_word(k);
            final_mem[k] = init_word(k);
        end
        for (int i = 0; i < N_OPS; i++) begin
            if (i >= 60 && i < 80) prog_is_store[i] = 1'b1;         // Store burst
            else if (i >= 120 && i < 140) prog_is_store[i] = 1'b0;  // Load burst
            else prog_is_store[i] = $random(seed) & 1;
            word = ($unsigned($random(seed)) % 4) * 5;              // Words 0, 5, 10, 15
            prog_addr[i] = addr_t'(word * 4);
            prog_data[i] = $random(seed);
            prog_exp[i]  = final_mem[word];
            if (prog_is_store[i]) final_mem[word] = prog_data[i];
            data_given[i] = 1'b0;
            wb_seen[i]    = 1'b0;
            drained[i]    = 1'b0;
            rd_count[i]   = 0;
        end
        data_ptr  = next_store_index(0);
        drain_ptr = next_store_index(0);
        wb_ptr    = next_load_index(0);
        repeat (2) @(posedge clock);
        reset <= 1'b1;
        while (!(commit_ptr == N_OPS && drain_ptr == N_OPS && !bus_active)
               && cycle_cnt < TIMEOUT_CYCLES) @(negedge clock);
        if (cycle_cnt < TIMEOUT_CYCLES) begin
            for (int k = 0; k < 16; k++) begin
                check_data($sformatf("slave_mem[%0d]", k), slave_mem[k], final_mem[k]);
            end
            if (!sq_full_seen || !lq_full_seen) abort_run("A burst never filled its queue");
            if (fwd_count == 0) abort_run("No load was served by store forwarding");
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // ==============================
    // Producer, memory slave, checks
    // ==============================
    // Samples pre-edge DUT outputs, then drives the next inputs
    always @(posedge clock) begin
        logic exp_full;
        int   word;
        if (reset) begin
            if (cycle_cnt == 0) begin                            // State right after reset
                check_flag("mem_req_o.cyc", mem_req_o.cyc, 1'b0);
                check_flag("mem_req_o.stb", mem_req_o.stb, 1'b0);
                check_flag("wb_valid_o", wb_valid_o, 1'b0);
            end
            cycle_cnt++;
            exp_full = dispatch_i.is_store ? (sq_cnt == SQ_DEPTH) : (lq_cnt == LQ_DEPTH);
            check_flag("lsq_full_o", lsq_full_o, exp_full);
            if (lsq_full_o && dispatch_i.is_store) sq_full_seen = 1'b1;
            if (lsq_full_o && !dispatch_i.is_store) lq_full_seen = 1'b1;
            if (dispatch_valid_i && !lsq_full_o) begin           // Accepted this edge
                if (dispatch_i.is_store) sq_cnt++;
                else lq_cnt++;
                disp_ptr++;
            end
            if (commit_valid_i && !commit_i.is_store) lq_cnt--;  // Load freed on commit

            if (wb_valid_o) begin
                if (wb_ptr >= disp_ptr) abort_run("Writeback with no load outstanding");
                check_rob("wb_load_o.rob_idx", wb_load_o.rob_idx, rob_idx_t'(wb_ptr));
                check_data("wb_load_o.data", wb_load_o.data, prog_exp[wb_ptr]);
                wb_seen[wb_ptr] = 1'b1;
                if (rd_count[wb_ptr] == 0) fwd_count++;
                wb_ptr = next_load_index(wb_ptr + 1);
            end

            // Wishbone slave
            check_flag("mem_req_o.stb", mem_req_o.stb, mem_req_o.cyc);
            if (mem_req_o.cyc) check_sel("mem_req_o.sel", mem_req_o.sel, 4'hf);  // Whole words
            if (drop_check) begin
                check_flag("mem_req_o.cyc", mem_req_o.cyc, 1'b0);  // Idle cycle after ack
                drop_check = 1'b0;
            end
            if (mem_rsp_i.ack) begin
                word = mem_req_o.adr[5:2];
                if (mem_req_o.we) begin
                    if (drain_ptr >= commit_ptr) abort_run("Store drained before its commit");
                    check_addr("mem_req_o.adr", mem_req_o.adr, prog_addr[drain_ptr]);
                    check_data("mem_req_o.dat", mem_req_o.dat, prog_data[drain_ptr]);
                    slave_mem[word] = mem_req_o.dat;
                    drained[drain_ptr] = 1'b1;
                    drain_ptr = next_store_index(drain_ptr + 1);
                    sq_cnt--;
                end else begin
                    if (wb_ptr >= N_OPS) abort_run("Memory read with no load outstanding");
                    check_addr("mem_req_o.adr", mem_req_o.adr, prog_addr[wb_ptr]);
                    for (int k = 0; k < wb_ptr; k++) begin
                        if (prog_is_store[k] && !drained[k] && prog_addr[k] == prog_addr[wb_ptr])
                            abort_run("Load read memory while an older store was still queued");
                    end
                    rd_count[wb_ptr]++;
                    if (rd_count[wb_ptr] > 1) abort_run("Load read memory more than once");
                end
                mem_rsp_i  <= '0;
                bus_active = 1'b0;
                drop_check = 1'b1;
            end else begin
                if (!bus_active && mem_req_o.cyc) begin          // New cycle
                    bus_active = 1'b1;
                    bus_wait   = $unsigned($random(seed)) % 4;
                    cap_adr    = mem_req_o.adr;
                    cap_we     = mem_req_o.we;
                    cap_dat    = mem_req_o.dat;
                end else if (bus_active) begin
                    check_flag("mem_req_o.cyc", mem_req_o.cyc, 1'b1);
                    check_addr("mem_req_o.adr", mem_req_o.adr, cap_adr);
                    check_flag("mem_req_o.we", mem_req_o.we, cap_we);
                    if (cap_we) check_data("mem_req_o.dat", mem_req_o.dat, cap_dat);
                end
                if (bus_active) begin
                    if (bus_wait == 0) begin
                        mem_rsp_i.ack <= 1'b1;
                        mem_rsp_i.dat <= cap_we ? '0 : slave_mem[cap_adr[5:2]];
                    end else begin
                        bus_wait--;
                    end
                end
            end

            // Dispatch with random bubbles, op held while full
            if (disp_ptr < N_OPS) begin
                dispatch_valid_i <= ($random(seed) & 7) != 0;
                dispatch_i <= '{is_store: prog_is_store[disp_ptr],
                                rob_idx: rob_idx_t'(disp_ptr), addr: prog_addr[disp_ptr]};
            end else begin
                dispatch_valid_i <= 1'b0;
            end
            store_data_valid_i <= 1'b0;
            if (data_ptr < disp_ptr) begin
                if (data_wait == 0) begin
                    store_data_valid_i <= 1'b1;
                    store_data_i <= '{rob_idx: rob_idx_t'(data_ptr), data: prog_data[data_ptr]};
                    data_given[data_ptr] = 1'b1;
                    data_ptr  = next_store_index(data_ptr + 1);
                    data_wait = $unsigned($random(seed)) % 6;
                end else begin
                    data_wait--;
                end
            end
            // Retire oldest once complete
            commit_valid_i <= 1'b0;
            if (commit_ptr < N_OPS && (prog_is_store[commit_ptr] ? data_given[commit_ptr]
                                                                  : wb_seen[commit_ptr])) begin
                commit_valid_i <= 1'b1;
                commit_i <= '{is_store: prog_is_store[commit_ptr],
                              rob_idx: rob_idx_t'(commit_ptr)};
                commit_ptr++;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsq_top.sv
`default_nettype none

module lsq_top import lsq_pkg::*; #(
    parameter int SQ_DEPTH = 8,
    parameter int LQ_DEPTH = 8
) (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        dispatch_valid_i,
    input  wire dispatch_t   dispatch_i,
    output logic             lsq_full_o,
    input  wire logic        store_data_valid_i,
    input  wire store_data_t store_data_i,
    input  wire logic        commit_valid_i,
    input  wire commit_t     commit_i,
    output logic             wb_valid_o,
    output load_wb_t         wb_load_o,
    output wb_req_t          mem_req_o,
    input  wire wb_rsp_t     mem_rsp_i
);

    localparam int SPW = $clog2(SQ_DEPTH) + 1;

    logic           sq_full, lq_full;
    logic           sq_enq, lq_enq;
    logic           sq_commit, lq_commit;
    logic [SPW-1:0] sq_tail, fwd_bound;
    addr_t          fwd_addr;
    fwd_result_t    fwd;
    logic           st_req, st_done, ld_req, ld_done;
    addr_t          st_addr, ld_addr;
    data_t          st_data, ld_data;

    // ==============================
    // Steering
    // ==============================
    assign lsq_full_o = dispatch_i.is_store ? sq_full : lq_full;  // Selected queue only
    assign sq_enq     = dispatch_valid_i && dispatch_i.is_store && !sq_full;
    assign lq_enq     = dispatch_valid_i && !dispatch_i.is_store && !lq_full;
    assign sq_commit  = commit_valid_i && commit_i.is_store;
    assign lq_commit  = commit_valid_i && !commit_i.is_store;

    store_queue #(.SQ_DEPTH(SQ_DEPTH)) store_queue_i (
        .clock, .reset,
        .enq_i(sq_enq), .enq_addr_i(dispatch_i.addr), .enq_rob_i(dispatch_i.rob_idx),
        .full_o(sq_full), .tail_o(sq_tail),
        .data_valid_i(store_data_valid_i), .data_i(store_data_i),
        .commit_i(sq_commit), .commit_rob_i(commit_i.rob_idx),
        .fwd_addr_i(fwd_addr), .fwd_bound_i(fwd_bound), .fwd_o(fwd),
        .drain_req_o(st_req), .drain_addr_o(st_addr), .drain_data_o(st_data),
        .drain_done_i(st_done)
    );

    load_queue #(.SQ_DEPTH(SQ_DEPTH), .LQ_DEPTH(LQ_DEPTH)) load_queue_i (
        .clock, .reset,
        .enq_i(lq_enq), .enq_addr_i(dispatch_i.addr), .enq_rob_i(dispatch_i.rob_idx),
        .sq_tail_i(sq_tail), .full_o(lq_full),
        .commit_i(lq_commit), .commit_rob_i(commit_i.rob_idx),
        .fwd_addr_o(fwd_addr), .fwd_bound_o(fwd_bound), .fwd_i(fwd),
        .rd_req_o(ld_req), .rd_addr_o(ld_addr), .rd_done_i(ld_done), .rd_data_i(ld_data),
        .wb_valid_o, .wb_o(wb_load_o)
    );

    // Single Wishbone port for both queues
    mem_port_arbiter mem_port_arbiter_i (
        .clock, .reset,
        .ld_req_i(ld_req), .ld_addr_i(ld_addr), .ld_done_o(ld_done), .ld_data_o(ld_data),
        .st_req_i(st_req), .st_addr_i(st_addr), .st_data_i(st_data), .st_done_o(st_done),
        .wb_o(mem_req_o), .wb_i(mem_rsp_i)
    );

endmodule

`default_nettype wire

// File: rtl/mem_port_arbiter.sv
`default_nettype none

module mem_port_arbiter import lsq_pkg::*; (
    input  wire logic    clock,
    input  wire logic    reset,
    input  wire logic    ld_req_i,
    input  wire addr_t   ld_addr_i,
    output logic         ld_done_o,
    output data_t        ld_data_o,
    input  wire logic    st_req_i,
    input  wire addr_t   st_addr_i,
    input  wire data_t   st_data_i,
    output logic         st_done_o,
    output wb_req_t      wb_o,
    input  wire wb_rsp_t wb_i
);

    arb_state_e state_q;

    // ==============================
    // Grant FSM
    // ==============================
    always_ff @(posedge clock) begin
        if (!reset) begin
            state_q <= ARB_IDLE;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (ld_req_i) begin
                        state_q <= ARB_LOAD;       // Load wins a tie
                    end else if (st_req_i) begin
                        state_q <= ARB_STORE;
                    end
                end
                ARB_LOAD, ARB_STORE: if (wb_i.ack) state_q <= ARB_IDLE;
                default:  state_q <= ARB_IDLE;
            endcase
        end
    end

    // Requesters hold their fields until done, so the bus stays stable
    always_comb begin
        wb_o     = '0;
        wb_o.cyc = (state_q != ARB_IDLE);
        wb_o.stb = (state_q != ARB_IDLE);
        wb_o.we  = (state_q == ARB_STORE);
        wb_o.adr = (state_q == ARB_STORE) ? st_addr_i : ld_addr_i;
        wb_o.dat = (state_q == ARB_STORE) ? st_data_i : '0;
        wb_o.sel = 4'hf;                            // Full words only
    end

    assign ld_done_o = (state_q == ARB_LOAD) && wb_i.ack;
    assign st_done_o = (state_q == ARB_STORE) && wb_i.ack;
    assign ld_data_o = wb_i.dat;

    a_stb_with_cyc: assert property (@(posedge clock) disable iff (!reset)
        $rose(wb_o.stb) |-> $rose(wb_o.cyc))
        else $error("stb raised without cyc");

    a_hold_until_ack: assert property (@(posedge clock) disable iff (!reset)
        wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.we))
        else $error("bus request changed before ack");

endmodule

`default_nettype wire

// File: rtl/load_queue.sv
`default_nettype none

module load_queue import lsq_pkg::*; #(
    parameter int SQ_DEPTH = 8,
    parameter int LQ_DEPTH = 8                       // Power of two
) (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        enq_i,
    input  wire addr_t                       enq_addr_i,
    input  wire rob_idx_t                    enq_rob_i,
    input  wire logic [$clog2(SQ_DEPTH):0]   sq_tail_i,
    output logic                             full_o,
    input  wire logic                        commit_i,
    input  wire rob_idx_t                    commit_rob_i,
    output addr_t                            fwd_addr_o,
    output logic [$clog2(SQ_DEPTH):0]        fwd_bound_o,
    input  wire fwd_result_t                 fwd_i,
    output logic                             rd_req_o,
    output addr_t                            rd_addr_o,
    input  wire logic                        rd_done_i,
    input  wire data_t                       rd_data_i,
    output logic                             wb_valid_o,
    output load_wb_t                         wb_o
);

    localparam int IW  = $clog2(LQ_DEPTH);
    localparam int CW  = $clog2(LQ_DEPTH + 1);
    localparam int SPW = $clog2(SQ_DEPTH) + 1;

    logic [IW-1:0]       head_q, tail_q;
    logic [CW-1:0]       count_q;
    logic [LQ_DEPTH-1:0] valid_q;
    logic [LQ_DEPTH-1:0] wb_done_q;  // Written back, waiting for commit

    addr_t          addr_q  [LQ_DEPTH];
    rob_idx_t       rob_q   [LQ_DEPTH];
    logic [SPW-1:0] bound_q [LQ_DEPTH];  // SQ tail at enqueue

    ld_state_e state_q, state_d;
    data_t     ld_data_q;                 // Head load result

    logic free;

    assign full_o = (count_q == CW'(LQ_DEPTH));
    assign free   = commit_i;             // Commit always frees the head

    // ==============================
    // Head issue FSM
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            LD_IDLE:  if (valid_q[head_q]) state_d = LD_CHECK;
            LD_CHECK: begin
                if (fwd_i.hit) begin
                    state_d = LD_WB;
                end else if (!fwd_i.pending) begin
                    state_d = LD_MEM;      // No older store to this word
                end
            end
            LD_MEM:   if (rd_done_i) state_d = LD_WB;
            LD_WB:    if (free) state_d = LD_IDLE;
            default:  state_d = LD_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state_q   <= LD_IDLE;
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            valid_q   <= '0;
            wb_done_q <= '0;
        end else begin
            state_q <= state_d;
            if (enq_i) begin
                valid_q[tail_q]   <= 1'b1;
                wb_done_q[tail_q] <= 1'b0;
                tail_q            <= tail_q + 1'b1;
            end
            if (wb_valid_o) wb_done_q[head_q] <= 1'b1;   // Only one writeback
            if (free) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + CW'(enq_i) - CW'(free);
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        if (enq_i) begin
            addr_q[tail_q]  <= enq_addr_i;
            rob_q[tail_q]   <= enq_rob_i;
            bound_q[tail_q] <= sq_tail_i;
        end
        if (state_q == LD_CHECK && fwd_i.hit) begin
            ld_data_q <= fwd_i.data;               // Forwarded word
        end else if (state_q == LD_MEM && rd_done_i) begin
            ld_data_q <= rd_data_i;
        end
    end

    // Forward query and memory read always use the head
    assign fwd_addr_o  = addr_q[head_q];
    assign fwd_bound_o = bound_q[head_q];
    assign rd_req_o    = (state_q == LD_MEM);
    assign rd_addr_o   = addr_q[head_q];

    assign wb_valid_o = (state_q == LD_WB) && !wb_done_q[head_q];
    assign wb_o       = '{rob_idx: rob_q[head_q], data: ld_data_q};

    a_commit_head: assert property (@(posedge clock) disable iff (!reset)
        commit_i |-> valid_q[head_q] && rob_q[head_q] == commit_rob_i)
        else $error("load commit does not match head");

    // Retirement must wait for the writeback pulse
    a_commit_after_wb: assert property (@(posedge clock) disable iff (!reset)
        commit_i |-> wb_done_q[head_q])
        else $error("load committed before writeback");

endmodule

`default_nettype wire

// File: rtl/store_queue.sv
`default_nettype none

module store_queue import lsq_pkg::*; #(
    parameter int SQ_DEPTH = 8                       // Power of two
) (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        enq_i,
    input  wire addr_t                       enq_addr_i,
    input  wire rob_idx_t                    enq_rob_i,
    output logic                             full_o,
    output logic [$clog2(SQ_DEPTH):0]        tail_o,  // Pointer with wrap bit
    input  wire logic                        data_valid_i,
    input  wire store_data_t                 data_i,
    input  wire logic                        commit_i,
    input  wire rob_idx_t                    commit_rob_i,
    input  wire addr_t                       fwd_addr_i,
    input  wire logic [$clog2(SQ_DEPTH):0]   fwd_bound_i,
    output fwd_result_t                      fwd_o,
    output logic                             drain_req_o,
    output addr_t                            drain_addr_o,
    output data_t                            drain_data_o,
    input  wire logic                        drain_done_i
);

    localparam int IW = $clog2(SQ_DEPTH);
    localparam int CW = $clog2(SQ_DEPTH + 1);

    typedef logic [IW:0] sq_ptr_t;    // Extra bit tells full from empty

    sq_ptr_t             head_q, tail_q;
    logic [IW-1:0]       cmt_idx_q;   // Oldest uncommitted entry
    logic [CW-1:0]       count_q;
    logic [SQ_DEPTH-1:0] valid_q, data_valid_q, committed_q;

    addr_t    addr_q [SQ_DEPTH];
    rob_idx_t rob_q  [SQ_DEPTH];
    data_t    data_q [SQ_DEPTH];

    logic [IW-1:0] head_idx, tail_idx;

    assign head_idx = head_q[IW-1:0];
    assign tail_idx = tail_q[IW-1:0];
    assign full_o   = (count_q == CW'(SQ_DEPTH));
    assign tail_o   = tail_q;

    // ==============================
    // Entry control
    // ==============================
    always_ff @(posedge clock) begin
        if (!reset) begin
            head_q       <= '0;
            tail_q       <= '0;
            cmt_idx_q    <= '0;
            count_q      <= '0;
            valid_q      <= '0;
            data_valid_q <= '0;
            committed_q  <= '0;
        end else begin
            if (enq_i) begin
                valid_q[tail_idx]      <= 1'b1;
                data_valid_q[tail_idx] <= 1'b0;
                committed_q[tail_idx]  <= 1'b0;
                tail_q                 <= tail_q + 1'b1;
            end
            // Data lands on the live store with the same rob tag
            if (data_valid_i) begin
                for (int i = 0; i < SQ_DEPTH; i++) begin
                    if (valid_q[i] && !data_valid_q[i] && rob_q[i] == data_i.rob_idx) begin
                        data_valid_q[i] <= 1'b1;
                    end
                end
            end
            if (commit_i) begin
                committed_q[cmt_idx_q] <= 1'b1;
                cmt_idx_q              <= cmt_idx_q + 1'b1;
            end
            if (drain_done_i) begin                  // Freed on the ack edge
                valid_q[head_idx] <= 1'b0;
                head_q            <= head_q + 1'b1;
            end
            count_q <= count_q + CW'(enq_i) - CW'(drain_done_i);
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        if (enq_i) begin
            addr_q[tail_idx] <= enq_addr_i;
            rob_q[tail_idx]  <= enq_rob_i;
        end
        if (data_valid_i) begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                if (valid_q[i] && !data_valid_q[i] && rob_q[i] == data_i.rob_idx) begin
                    data_q[i] <= data_i.data;
                end
            end
        end
    end

    // ==============================
    // Forwarding search
    // ==============================
    // Walk back from the load's bound, first match is youngest
    always_comb begin
        sq_ptr_t       n_older;
        sq_ptr_t       pos;
        logic [IW-1:0] idx;
        logic          found;
        n_older = fwd_bound_i - head_q;
        found   = 1'b0;
        fwd_o   = '0;
        for (int i = 1; i <= SQ_DEPTH; i++) begin
            pos = fwd_bound_i - sq_ptr_t'(i);
            idx = pos[IW-1:0];
            if (!found && i <= n_older && addr_q[idx] == fwd_addr_i) begin
                found         = 1'b1;
                fwd_o.hit     = data_valid_q[idx];
                fwd_o.pending = !data_valid_q[idx];
                fwd_o.data    = data_q[idx];
            end
        end
    end

    // Drain the head once retired and complete
    assign drain_req_o  = valid_q[head_idx] && committed_q[head_idx] && data_valid_q[head_idx];
    assign drain_addr_o = addr_q[head_idx];
    assign drain_data_o = data_q[head_idx];

    // Commit order must follow the queue order
    a_commit_oldest: assert property (@(posedge clock) disable iff (!reset)
        commit_i |-> valid_q[cmt_idx_q] && !committed_q[cmt_idx_q]
                     && rob_q[cmt_idx_q] == commit_rob_i)
        else $error("store commit out of order");

    a_no_enq_full: assert property (@(posedge clock) disable iff (!reset)
        enq_i |-> !full_o)
        else $error("store enqueue while full");

endmodule

`default_nettype wire

// File: rtl/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    // ==============================
    // Basic widths
    // ==============================
    typedef logic [5:0]  rob_idx_t;  // Reorder buffer slot
    typedef logic [31:0] addr_t;     // Byte address, word aligned
    typedef logic [31:0] data_t;     // One 32-bit word

    // ==============================
    // Pipeline records
    // ==============================
    typedef struct packed {
        logic     is_store;          // 1 store, 0 load
        rob_idx_t rob_idx;
        addr_t    addr;
    } dispatch_t;

    typedef struct packed {
        rob_idx_t rob_idx;           // Owning store
        data_t    data;
    } store_data_t;

    typedef struct packed {
        logic     is_store;
        rob_idx_t rob_idx;           // Oldest instruction retiring
    } commit_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        data_t    data;              // Loaded word
    } load_wb_t;

    typedef struct packed {
        logic     hit;               // Older store with data
        logic     pending;           // Older store, data not yet there
        data_t    data;
    } fwd_result_t;

    // ==============================
    // Wishbone classic
    // ==============================
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        addr_t      adr;
        data_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

    // State machines
    typedef enum logic [1:0] {LD_IDLE, LD_CHECK, LD_MEM, LD_WB} ld_state_e;
    typedef enum logic [1:0] {ARB_IDLE, ARB_LOAD, ARB_STORE} arb_state_e;

endpackage

`default_nettype wire
